/* include/iir_config.svh */
// Width and size macros for the biquad cascade, included by the package and every RTL module
`ifndef IIR_CONFIG_SVH
`define IIR_CONFIG_SVH

// Sample and coefficient word width
`define IIR_DATA_W 16

// Accumulator width, wraps modulo 2^32
`define IIR_ACC_W 32

// Q2.14 coefficients, also the output shift
`define IIR_COEF_FRAC 14

// Number of cascaded biquads (1 to 4)
`define IIR_NUM_SECTIONS 2

// Index of a coefficient inside one set, 0 = b0 up to 4 = a2
`define IIR_COEF_IDX_W 3

`endif

/* logic/iir_pkg.sv */
// Shared sample, coefficient and MAC command types for the biquad cascade RTL and testbench
`include "iir_config.svh"

package iir_pkg;

    // Section select width, at least one bit
    localparam int unsigned IIR_SECT_W =
        (`IIR_NUM_SECTIONS > 1) ? $clog2(`IIR_NUM_SECTIONS) : 1;

    // One sample moving between sections
    typedef struct packed {
        logic                          valid; // One-cycle strobe
        logic signed [`IIR_DATA_W-1:0] data;
    } sample_t;

    // Coefficients of one section, all Q2.14
    typedef struct packed {
        logic signed [`IIR_DATA_W-1:0] b0;
        logic signed [`IIR_DATA_W-1:0] b1;
        logic signed [`IIR_DATA_W-1:0] b2;
        logic signed [`IIR_DATA_W-1:0] a1;
        logic signed [`IIR_DATA_W-1:0] a2;
    } coef_set_t;

    // One coefficient write
    typedef struct packed {
        logic                          en;
        logic [IIR_SECT_W-1:0]         sect;
        logic [`IIR_COEF_IDX_W-1:0]    idx;  // 0 = b0 ... 4 = a2
        logic signed [`IIR_DATA_W-1:0] data;
    } coef_wr_t;

    // Command from a section to its MAC
    typedef enum logic [1:0] {
        MAC_LOAD_ADD = 2'd0,  // acc = a*b
        MAC_ACC_ADD  = 2'd1,  // acc += a*b
        MAC_ACC_SUB  = 2'd2   // acc -= a*b
    } mac_op_t;

endpackage

/* logic/mac_unit.sv */
// Behavioral signed 16x16 multiply-accumulate unit, one instance per biquad section
`include "iir_config.svh"

module mac_unit
    import iir_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          en_i,   // Update accumulator this edge
    input  mac_op_t                       op_i,
    input  logic signed [`IIR_DATA_W-1:0] a_i,    // Coefficient
    input  logic signed [`IIR_DATA_W-1:0] b_i,    // History sample
    output logic signed [`IIR_ACC_W-1:0]  acc_o
);

    logic signed [`IIR_ACC_W-1:0] prod;
    logic signed [`IIR_ACC_W-1:0] acc_q;

    // Full-width signed product, both operands sign-extended
    assign prod = a_i * b_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_q <= '0;
        end else if (en_i) begin
            case (op_i)
                MAC_LOAD_ADD: acc_q <= prod;          // Start of a new sum
                MAC_ACC_ADD:  acc_q <= acc_q + prod;  // Wraps mod 2^32
                MAC_ACC_SUB:  acc_q <= acc_q - prod;
                default:      acc_q <= acc_q;
            endcase
        end
    end

    assign acc_o = acc_q;

    // Section must always issue a known command
    a_op_known: assert property (
        @(posedge clk) disable iff (reset)
        en_i |-> !$isunknown(op_i)
    ) else $error("mac_unit: unknown op with enable high");

endmodule

/* logic/biquad_section.sv */
// Direct-form-I biquad section, five products over one shared MAC, chained by the cascade top
`include "iir_config.svh"

module biquad_section
    import iir_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  coef_set_t coef_i,    // Read in every product state
    input  sample_t   sample_i,  // Taken only when idle
    output sample_t   sample_o   // One-cycle strobe with y[n]
);

    localparam int unsigned Y_LSB = `IIR_COEF_FRAC;
    localparam int unsigned Y_MSB = `IIR_COEF_FRAC + `IIR_DATA_W - 1;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_P0    = 3'd1,  // b0 * x[n]
        ST_P1    = 3'd2,  // + b1 * x[n-1]
        ST_P2    = 3'd3,  // + b2 * x[n-2]
        ST_P3    = 3'd4,  // - a1 * y[n-1]
        ST_P4    = 3'd5,  // - a2 * y[n-2]
        ST_DRAIN = 3'd6,  // Last product lands in acc
        ST_DONE  = 3'd7
    } state_t;

    state_t state;
    state_t state_nxt;

    // History registers cleared by reset
    logic signed [`IIR_DATA_W-1:0] x0;
    logic signed [`IIR_DATA_W-1:0] x1;
    logic signed [`IIR_DATA_W-1:0] x2;
    logic signed [`IIR_DATA_W-1:0] y1;
    logic signed [`IIR_DATA_W-1:0] y2;

    logic                          mac_en;
    mac_op_t                       mac_op;
    logic signed [`IIR_DATA_W-1:0] mac_a;
    logic signed [`IIR_DATA_W-1:0] mac_b;
    logic signed [`IIR_ACC_W-1:0]  mac_acc;
    logic signed [`IIR_DATA_W-1:0] y_new;

    mac_unit i_mac_unit (
        .clk   (clk),
        .reset (reset),
        .en_i  (mac_en),
        .op_i  (mac_op),
        .a_i   (mac_a),
        .b_i   (mac_b),
        .acc_o (mac_acc)
    );

    // Arithmetic shift by 14 keeping 16 bits with wrap
    assign y_new = mac_acc[Y_MSB:Y_LSB];

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (sample_i.valid) state_nxt = ST_P0;
            ST_P0:    state_nxt = ST_P1;
            ST_P1:    state_nxt = ST_P2;
            ST_P2:    state_nxt = ST_P3;
            ST_P3:    state_nxt = ST_P4;
            ST_P4:    state_nxt = ST_DRAIN;
            ST_DRAIN: state_nxt = ST_DONE;
            ST_DONE:  state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Operand and command select for the shared MAC
    always_comb begin
        mac_en = 1'b1;
        mac_op = MAC_ACC_ADD;
        mac_a  = coef_i.b0;
        mac_b  = x0;
        case (state)
            ST_P0: mac_op = MAC_LOAD_ADD;
            ST_P1: begin
                mac_a = coef_i.b1;
                mac_b = x1;
            end
            ST_P2: begin
                mac_a = coef_i.b2;
                mac_b = x2;
            end
            ST_P3: begin
                mac_op = MAC_ACC_SUB;  // Feedback terms subtract
                mac_a  = coef_i.a1;
                mac_b  = y1;
            end
            ST_P4: begin
                mac_op = MAC_ACC_SUB;
                mac_a  = coef_i.a2;
                mac_b  = y2;
            end
            default: mac_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x0 <= '0;
            x1 <= '0;
            x2 <= '0;
            y1 <= '0;
            y2 <= '0;
        end else if (state == ST_IDLE && sample_i.valid) begin
            x0 <= sample_i.data;
        end else if (state == ST_DONE) begin
            // Shift history once y[n] has gone out
            x1 <= x0;
            x2 <= x1;
            y1 <= y_new;
            y2 <= y1;
        end
    end

    assign sample_o.valid = (state == ST_DONE);
    assign sample_o.data  = y_new;

    a_state_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(state)
    ) else $error("biquad_section: state register unknown");

    a_strobe_single: assert property (
        @(posedge clk) disable iff (reset)
        sample_o.valid |=> !sample_o.valid
    ) else $error("biquad_section: output strobe longer than one cycle");

endmodule

/* logic/coef_bank.sv */
// Coefficient register file with one Q2.14 set per biquad section, loaded through the write port
`include "iir_config.svh"

module coef_bank
    import iir_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  coef_wr_t                              coef_wr_i,
    output coef_set_t [`IIR_NUM_SECTIONS-1:0]     coef_o
);

    coef_set_t [`IIR_NUM_SECTIONS-1:0] bank_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_q <= '0;
        end else if (coef_wr_i.en) begin
            for (int s = 0; s < `IIR_NUM_SECTIONS; s++) begin
                if (coef_wr_i.sect == IIR_SECT_W'(s)) begin
                    case (coef_wr_i.idx)
                        `IIR_COEF_IDX_W'(0): bank_q[s].b0 <= coef_wr_i.data;
                        `IIR_COEF_IDX_W'(1): bank_q[s].b1 <= coef_wr_i.data;
                        `IIR_COEF_IDX_W'(2): bank_q[s].b2 <= coef_wr_i.data;
                        `IIR_COEF_IDX_W'(3): bank_q[s].a1 <= coef_wr_i.data;
                        `IIR_COEF_IDX_W'(4): bank_q[s].a2 <= coef_wr_i.data;
                        default: ;  // Out of range, flagged below
                    endcase
                end
            end
        end
    end

    // Visible to the sections the cycle after the write
    assign coef_o = bank_q;

    a_wr_in_range: assert property (
        @(posedge clk) disable iff (reset)
        coef_wr_i.en |-> (coef_wr_i.sect < `IIR_NUM_SECTIONS) && (coef_wr_i.idx <= 4)
    ) else $error("coef_bank: write to section %0d index %0d out of range",
                  coef_wr_i.sect, coef_wr_i.idx);

endmodule

/* logic/iir_cascade_top.sv */
// Top of the biquad cascade, joining the coefficient bank to a chain of time-multiplexed sections
`include "iir_config.svh"

module iir_cascade_top
    import iir_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  sample_t  sample_i,   // Spaced at least 8 cycles apart
    input  coef_wr_t coef_wr_i,
    output sample_t  sample_o    // Last section output
);

    coef_set_t [`IIR_NUM_SECTIONS-1:0] coef;

    // Link k feeds section k, the last link is the output
    sample_t [`IIR_NUM_SECTIONS:0] link;

    coef_bank i_coef_bank (
        .clk       (clk),
        .reset     (reset),
        .coef_wr_i (coef_wr_i),
        .coef_o    (coef)
    );

    assign link[0] = sample_i;

    for (genvar k = 0; k < `IIR_NUM_SECTIONS; k++) begin : g_section
        biquad_section i_biquad_section (
            .clk      (clk),
            .reset    (reset),
            .coef_i   (coef[k]),
            .sample_i (link[k]),
            .sample_o (link[k+1])
        );
    end

    assign sample_o = link[`IIR_NUM_SECTIONS];  // 7 cycles per section behind the input

endmodule

/* verif/iir_cascade_tb.sv */
// Self-checking testbench for the biquad cascade, compiled as top module through build.f
`include "iir_config.svh"

module iir_cascade_tb
    import iir_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int NS         = `IIR_NUM_SECTIONS;
    localparam int LATENCY    = 7 * NS;  // Seven cycles per section
    localparam int N_IDENT    = 10;
    localparam int N_FIR      = 16;
    localparam int N_IMP      = 24;
    localparam int N_RAND     = 64;
    localparam int N_CHG      = 20;
    localparam int N_TOTAL    = N_IDENT + N_FIR + N_IMP + N_RAND + N_CHG;
    // Worst spacing is 12 cycles, margin covers drains and coefficient loads
    localparam int TIMEOUT_CYCLES = N_TOTAL * 16 + 2000;

    logic     clk;
    logic     reset;
    sample_t  sample_i;
    coef_wr_t coef_wr_i;
    sample_t  sample_o;

    logic [31:0] lcg_state = 32'ha6ab_6781;
    int          cycle_cnt = 0;
    int          in_count;
    int          out_count;
    sample_t     exp_q[$];     // Expected outputs in order
    int          start_q[$];   // Cycle of each input strobe

    // Model state per section
    coef_set_t                     coef_model [NS];
    logic signed [`IIR_DATA_W-1:0] hx1 [NS];
    logic signed [`IIR_DATA_W-1:0] hx2 [NS];
    logic signed [`IIR_DATA_W-1:0] hy1 [NS];
    logic signed [`IIR_DATA_W-1:0] hy2 [NS];

    iir_cascade_top i_iir_cascade_top (
        .clk       (clk),
        .reset     (reset),
        .sample_i  (sample_i),
        .coef_wr_i (coef_wr_i),
        .sample_o  (sample_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp_s);
        if (got !== exp_s) begin
            stop_on_error($sformatf("FAILED at %0t: output %0d, expected %0d",
                                    $time, got.data, exp_s.data));
        end
    endtask

    task automatic check_latency(input int cycles);
        if (cycles != LATENCY) begin
            stop_on_error($sformatf("FAILED at %0t: latency %0d cycles, expected %0d",
                                    $time, cycles, LATENCY));
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic signed [`IIR_DATA_W-1:0] rand_word();
        logic [31:0] r;
        r = next_rand();
        return r[31:16];  // Upper bits have the longer period
    endfunction

    function automatic coef_set_t make_set(
        input int b0,
        input int b1,
        input int b2,
        input int a1,
        input int a2
    );
        coef_set_t c;
        c.b0 = `IIR_DATA_W'(b0);
        c.b1 = `IIR_DATA_W'(b1);
        c.b2 = `IIR_DATA_W'(b2);
        c.a1 = `IIR_DATA_W'(a1);
        c.a2 = `IIR_DATA_W'(a2);
        return c;
    endfunction

    // Direct-form-I step with 32-bit wrap, then bits 29..14 as y[n]
    function automatic logic signed [`IIR_DATA_W-1:0] ref_biquad(
        input coef_set_t                     c,
        input int                            s,
        input logic signed [`IIR_DATA_W-1:0] x
    );
        int                            acc;
        logic signed [`IIR_DATA_W-1:0] y;
        acc = int'(c.b0) * int'(x) + int'(c.b1) * int'(hx1[s]) + int'(c.b2) * int'(hx2[s])
            - int'(c.a1) * int'(hy1[s]) - int'(c.a2) * int'(hy2[s]);
        y = acc[`IIR_COEF_FRAC + `IIR_DATA_W - 1:`IIR_COEF_FRAC];
        hx2[s] = hx1[s];
        hx1[s] = x;
        hy2[s] = hy1[s];
        hy1[s] = y;
        return y;
    endfunction

    function automatic sample_t ref_cascade(input logic signed [`IIR_DATA_W-1:0] x);
        logic signed [`IIR_DATA_W-1:0] v;
        sample_t                       r;
        v = x;
        for (int s = 0; s < NS; s++) begin
            v = ref_biquad(coef_model[s], s, v);
        end
        r.valid = 1'b1;
        r.data  = v;
        return r;
    endfunction

    task automatic write_coef(input int s, input int idx, input int d);
        @(negedge clk);
        coef_wr_i.en   = 1'b1;
        coef_wr_i.sect = IIR_SECT_W'(s);
        coef_wr_i.idx  = `IIR_COEF_IDX_W'(idx);
        coef_wr_i.data = `IIR_DATA_W'(d);
        @(negedge clk);
        coef_wr_i.en = 1'b0;
        case (idx)
            0: coef_model[s].b0 = `IIR_DATA_W'(d);
            1: coef_model[s].b1 = `IIR_DATA_W'(d);
            2: coef_model[s].b2 = `IIR_DATA_W'(d);
            3: coef_model[s].a1 = `IIR_DATA_W'(d);
            default: coef_model[s].a2 = `IIR_DATA_W'(d);
        endcase
    endtask

    task automatic load_set(input int s, input coef_set_t c);
        write_coef(s, 0, int'(c.b0));
        write_coef(s, 1, int'(c.b1));
        write_coef(s, 2, int'(c.b2));
        write_coef(s, 3, int'(c.a1));
        write_coef(s, 4, int'(c.a2));
    endtask

    // Strobe one sample, then hold the strobe low for the rest of the gap
    task automatic send_sample(input logic signed [`IIR_DATA_W-1:0] x, input int gap);
        @(negedge clk);
        sample_i.valid = 1'b1;
        sample_i.data  = x;
        exp_q.push_back(ref_cascade(x));
        start_q.push_back(cycle_cnt);
        in_count++;
        repeat (gap - 1) begin
            @(negedge clk);
            sample_i.valid = 1'b0;
        end
    endtask

    function automatic int rand_gap();
        return 8 + int'(next_rand() % 32'd5);
    endfunction

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // Compare process, outputs are stable at the falling edge
    always @(negedge clk) begin
        sample_t exp_s;
        int      start;
        if (!reset && sample_o.valid) begin
            out_count++;
            if (exp_q.size() == 0) begin
                stop_on_error("Output strobe arrived with no input sample pending");
            end else begin
                exp_s = exp_q.pop_front();
                start = start_q.pop_front();
                check_sample(sample_o, exp_s);
                check_latency(cycle_cnt - start);
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_on_error($sformatf("Timeout: test did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
    end

    initial begin
        reset     = 1'b1;
        sample_i  = '0;
        coef_wr_i = '0;
        in_count  = 0;
        out_count = 0;
        for (int s = 0; s < NS; s++) begin
            coef_model[s] = '0;
            hx1[s] = '0;
            hx2[s] = '0;
            hy1[s] = '0;
            hy2[s] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Quiet output after reset, then unity gain in every section
        repeat (20) @(negedge clk);
        for (int s = 0; s < NS; s++) load_set(s, make_set(16384, 0, 0, 0, 0));
        for (int i = 0; i < N_IDENT; i++) send_sample(rand_word(), 8);
        wait_drain();

        // FIR only
        load_set(0, make_set(4096, 8192, 4096, 0, 0));
        for (int s = 1; s < NS; s++) load_set(s, make_set(16384, -8192, 2048, 0, 0));
        for (int i = 0; i < N_FIR; i++) send_sample(rand_word(), rand_gap());
        wait_drain();

        // Impulse into recursive sections, poles inside the unit circle
        load_set(0, make_set(16384, 0, 0, -24576, 11469));
        for (int s = 1; s < NS; s++) load_set(s, make_set(8192, 8192, 0, -8192, 4096));
        send_sample(16'sd8000, 8);
        for (int i = 1; i < N_IMP; i++) send_sample(16'sd0, 8);
        wait_drain();

        // Full-scale random, two samples in flight
        for (int s = 0; s < NS; s++) begin
            load_set(s, make_set(rand_word(), rand_word(), rand_word(),
                                 rand_word(), rand_word()));
        end
        for (int i = 0; i < N_RAND; i++) send_sample(rand_word(), rand_gap());
        wait_drain();

        // Coefficient change mid-stream, history carries on
        for (int s = 0; s < NS; s++) load_set(s, make_set(6000, 4000, 2000, -8000, 3000));
        for (int i = 0; i < N_CHG / 2; i++) send_sample(rand_word() >>> 2, rand_gap());
        wait_drain();
        write_coef(NS - 1, 0, 12000);
        write_coef(NS - 1, 3, -16000);
        for (int i = N_CHG / 2; i < N_CHG; i++) send_sample(rand_word() >>> 2, rand_gap());
        wait_drain();

        if (out_count != in_count) begin
            stop_on_error($sformatf("Output count %0d does not match input count %0d",
                                    out_count, in_count));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* build.f */
+incdir+include
logic/iir_pkg.sv
logic/mac_unit.sv
logic/biquad_section.sv
logic/coef_bank.sv
logic/iir_cascade_top.sv
verif/iir_cascade_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= iir_cascade_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
